/* design/tcb_logsize2byteena.sv */
////////////////////
// log-size to byte-enable request converter
// write data replication, byte enables
// delayed offset/size and read data steering
////////////////////

`timescale 1ns/1ps

module tcb_logsize2byteena
  import tcb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // subordinate side, manager connects here
  input  logic         sub_vld,
  input  tcb_req_log_t sub_req,
  output logic         sub_rsp_vld,
  output tcb_rsp_t     sub_rsp,
  // manager side, memory connects here
  output logic         man_vld,
  output tcb_req_ben_t man_req,
  input  logic         man_rsp_vld,
  input  tcb_rsp_t     man_rsp
);

  // offset rounded down to the transfer size
  function automatic logic [TCB_OFF_W-1:0] off_align(
    input logic [TCB_OFF_W-1:0] off,
    input tcb_siz_t             siz
  );
    case (siz)
      TCB_BYTE: off_align = off;
      TCB_HALF: off_align = {off[1], 1'b0};
      default:  off_align = '0;
    endcase
  endfunction

  ////////////////////
  // request
  ////////////////////

  // lane views of write data
  logic [TCB_BEN-1:0][TCB_UNT-1:0] sub_req_wdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] man_req_wdt;
  // size thermometer and lane enables
  logic [TCB_BEN-1:0]              req_thm;
  logic [TCB_BEN-1:0]              req_ben;
  logic [TCB_OFF_W-1:0]            req_off;

  // valid and write enable pass straight through
  assign man_vld     = sub_vld;
  assign man_req.wen = sub_req.wen;

  // low address bits cleared
  assign man_req.adr = {sub_req.adr[TCB_ADR_W-1:TCB_OFF_W], TCB_OFF_W'(0)};

  assign req_off = off_align(sub_req.adr[TCB_OFF_W-1:0], sub_req.siz);

  // ones in the low 2**siz lanes
  always_comb begin
    case (sub_req.siz)
      TCB_BYTE: req_thm = 4'b0001;
      TCB_HALF: req_thm = 4'b0011;
      default:  req_thm = 4'b1111;
    endcase
  end

  // thermometer rotated up to the offset
  always_comb begin
    for (int i = 0; i < TCB_BEN; i++) begin
      req_ben[i] = req_thm[TCB_OFF_W'(i - req_off)];
    end
  end

  assign man_req.ben = req_ben;

  // replicate low bytes so every enabled lane sees its data
  assign sub_req_wdt = sub_req.wdt;
  always_comb begin
    case (sub_req.siz)
      TCB_BYTE: man_req_wdt = {4{sub_req_wdt[0]}};
      TCB_HALF: man_req_wdt = {2{sub_req_wdt[1:0]}};
      default:  man_req_wdt = sub_req_wdt;
    endcase
  end

  assign man_req.wdt = man_req_wdt;

  ////////////////////
  // delay line
  ////////////////////

  // attributes of the live request
  tcb_dly_t dly_req;
  // one stage per latency cycle
  tcb_dly_t dly [1:TCB_DLY];

  assign dly_req = '{off: sub_req.adr[TCB_OFF_W-1:0], siz: sub_req.siz};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 1; k <= TCB_DLY; k++) begin
        dly[k] <= '{off: '0, siz: TCB_BYTE};
      end
    end else begin
      dly[1] <= dly_req;
      for (int k = 2; k <= TCB_DLY; k++) begin
        dly[k] <= dly[k-1];
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  logic [TCB_OFF_W-1:0]            rsp_off;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] rsp_dtw;
  logic [1:0][TCB_UNT-1:0]         rsp_dth;
  logic [TCB_UNT-1:0]              rsp_dtb;

  // offset of the request now being answered
  assign rsp_off = off_align(dly[TCB_DLY].off, dly[TCB_DLY].siz);

  // word, then half by off[1], then byte by off[0]
  assign rsp_dtw = man_rsp.rdt;
  assign rsp_dth = rsp_off[1] ? rsp_dtw[3:2] : rsp_dtw[1:0];
  assign rsp_dtb = rsp_off[0] ? rsp_dth[1] : rsp_dth[0];

  // upper lanes only meaningful for word reads
  assign sub_rsp.rdt = {rsp_dtw[3:2], rsp_dth[1], rsp_dtb};
  assign sub_rsp.sts = man_rsp.sts;
  assign sub_rsp_vld = man_rsp_vld;

endmodule: tcb_logsize2byteena

/* design/tcb_mem.sv */
////////////////////
// byte-enable word memory
// one cycle read latency, error above depth
////////////////////

`timescale 1ns/1ps

module tcb_mem
  import tcb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // request
  input  logic         vld,
  input  tcb_req_ben_t req,
  // response
  output logic         rsp_vld,
  output tcb_rsp_t     rsp
);

  ////////////////////
  // storage
  ////////////////////

  logic [TCB_BEN-1:0][TCB_UNT-1:0] mem [TCB_MEM_WORDS];

  // word index and range check
  logic [TCB_ADR_W-TCB_OFF_W-1:0]  req_wrd;
  logic [TCB_IDX_W-1:0]            req_idx;
  logic                            req_inr;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] req_wdt;

  assign req_wrd = req.adr[TCB_ADR_W-1:TCB_OFF_W];
  assign req_idx = req.adr[TCB_OFF_W +: TCB_IDX_W];
  assign req_inr = (req_wrd < TCB_MEM_WORDS);
  assign req_wdt = req.wdt;

  // write, only enabled lanes, only in range
  always_ff @(posedge clk) begin
    if (vld && req.wen && req_inr) begin
      for (int i = 0; i < TCB_BEN; i++) begin
        if (req.ben[i]) begin
          mem[req_idx][i] <= req_wdt[i];
        end
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  // read data and status, old word on a write
  always_ff @(posedge clk) begin
    if (vld) begin
      if (req_inr) begin
        rsp.rdt <= mem[req_idx];
        rsp.sts <= TCB_OK;
      end else begin
        // out of range, zero word
        rsp.rdt <= '0;
        rsp.sts <= TCB_ERR;
      end
    end
  end

  // response valid one cycle after request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

endmodule: tcb_mem

/* design/tcb_pkg.sv */
////////////////////
// tightly coupled bus package
// bus widths, size and status codes
// request, response and delay structs
////////////////////

package tcb_pkg;

  ////////////////////
  // bus dimensions
  ////////////////////

  // byte address width
  localparam int unsigned TCB_ADR_W = 10;
  // byte lanes and bits per lane
  localparam int unsigned TCB_BEN   = 4;
  localparam int unsigned TCB_UNT   = 8;
  localparam int unsigned TCB_DAT_W = TCB_BEN * TCB_UNT;
  // byte offset within a word
  localparam int unsigned TCB_OFF_W = $clog2(TCB_BEN);
  // memory read latency in cycles
  localparam int unsigned TCB_DLY   = 1;
  // memory depth, covers byte addresses 0 to 255
  localparam int unsigned TCB_MEM_WORDS = 64;
  localparam int unsigned TCB_IDX_W     = $clog2(TCB_MEM_WORDS);

  ////////////////////
  // codes
  ////////////////////

  // log2 of the transfer size in bytes, code 3 is illegal
  typedef enum logic [1:0] {
    TCB_BYTE = 2'd0,
    TCB_HALF = 2'd1,
    TCB_WORD = 2'd2
  } tcb_siz_t;

  // response status
  typedef enum logic {
    TCB_OK  = 1'b0,
    TCB_ERR = 1'b1
  } tcb_sts_t;

  ////////////////////
  // structs
  ////////////////////

  // log-size request, write data right-aligned
  typedef struct packed {
    logic                 wen;
    logic [TCB_ADR_W-1:0] adr;
    tcb_siz_t             siz;
    logic [TCB_DAT_W-1:0] wdt;
  } tcb_req_log_t;

  // byte-enable request, address word aligned
  typedef struct packed {
    logic                 wen;
    logic [TCB_ADR_W-1:0] adr;
    logic [TCB_BEN-1:0]   ben;
    logic [TCB_DAT_W-1:0] wdt;
  } tcb_req_ben_t;

  // response
  typedef struct packed {
    logic [TCB_DAT_W-1:0] rdt;
    tcb_sts_t             sts;
  } tcb_rsp_t;

  // request attributes kept until the response returns
  typedef struct packed {
    logic [TCB_OFF_W-1:0] off;
    tcb_siz_t             siz;
  } tcb_dly_t;

endpackage: tcb_pkg

/* design/tcb_top.sv */
////////////////////
// subsystem top
// log-size converter feeding the memory
////////////////////

`timescale 1ns/1ps

module tcb_top
  import tcb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // log-size request from manager
  input  logic         req_vld,
  input  tcb_req_log_t req,
  // response back to manager
  output logic         rsp_vld,
  output tcb_rsp_t     rsp
);

  // converter to memory
  logic         man_vld;
  tcb_req_ben_t man_req;
  logic         mem_rsp_vld;
  tcb_rsp_t     mem_rsp;

  // request conversion and read steering
  tcb_logsize2byteena cnv_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sub_vld     (req_vld),
    .sub_req     (req),
    .sub_rsp_vld (rsp_vld),
    .sub_rsp     (rsp),
    .man_vld     (man_vld),
    .man_req     (man_req),
    .man_rsp_vld (mem_rsp_vld),
    .man_rsp     (mem_rsp)
  );

  // byte-enable memory
  tcb_mem mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (man_vld),
    .req     (man_req),
    .rsp_vld (mem_rsp_vld),
    .rsp     (mem_rsp)
  );

endmodule: tcb_top

/* run.sh */
#!/bin/sh
# build and run the bus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module tcb_tb \
  -f sources.f \
  --Mdir obj_dir -o tcb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tcb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

/* sources.f */
design/tcb_pkg.sv
design/tcb_logsize2byteena.sv
design/tcb_mem.sv
design/tcb_top.sv
tb/tcb_chk.sv
tb/tcb_tb.sv

/* tb/tcb_chk.sv */
////////////////////
// converter assertions
// byte enable patterns, response valid,
// valid after reset, delayed response attributes
////////////////////

`timescale 1ns/1ps

module tcb_chk
  import tcb_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  input logic         sub_vld,
  input tcb_req_log_t sub_req,
  input logic         sub_rsp_vld,
  input logic         man_vld,
  input tcb_req_ben_t man_req,
  input logic         man_rsp_vld,
  input tcb_dly_t     rsp_dly
);

  // attributes of the request now in the memory
  tcb_dly_t chk_dly;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chk_dly <= '{off: '0, siz: TCB_BYTE};
    end else if (sub_vld) begin
      chk_dly <= '{off: sub_req.adr[TCB_OFF_W-1:0], siz: sub_req.siz};
    end
  end

  ////////////////////
  // properties
  ////////////////////

  // single lanes, aligned halves or full word
  a_ben_legal: assert property (@(posedge clk) disable iff (!rst_n)
    man_vld |-> (man_req.ben inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                     4'b0011, 4'b1100, 4'b1111}))
    else $error("illegal byte enable pattern %b", man_req.ben);

  // response valid is a straight pass through
  a_rsp_vld: assert property (@(posedge clk) disable iff (!rst_n)
    sub_rsp_vld == man_rsp_vld)
    else $error("response valid differs from memory response valid");

  // first cycle out of reset carries no request
  a_rst_vld: assert property (@(posedge clk) $rose(rst_n) |-> !man_vld)
    else $error("request valid high right after reset");

  // steering uses the offset and size of the answered request
  a_rsp_dly: assert property (@(posedge clk) disable iff (!rst_n)
    sub_rsp_vld |-> (rsp_dly == chk_dly))
    else $error("delayed offset or size differs from the answered request");

endmodule: tcb_chk

bind tcb_logsize2byteena tcb_chk chk_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .sub_vld     (sub_vld),
  .sub_req     (sub_req),
  .sub_rsp_vld (sub_rsp_vld),
  .man_vld     (man_vld),
  .man_req     (man_req),
  .man_rsp_vld (man_rsp_vld),
  .rsp_dly     (dly[TCB_DLY])
);

/* tb/tcb_tb.sv */
////////////////////
// directed testbench for the bus subsystem
// clock, reset, byte array reference model
// request task, checks and closing report
////////////////////

`timescale 1ns/1ps

module tcb_tb
  import tcb_pkg::*;
();

  logic         clk;
  logic         rst_n;
  logic         req_vld;
  tcb_req_log_t req;
  logic         rsp_vld;
  tcb_rsp_t     rsp;

  int unsigned  err_cnt;
  int unsigned  chk_cnt;
  logic [31:0]  rnd_state;
  // reference memory, one entry per byte address
  logic [7:0]   mdl [256];

  tcb_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // every byte follows the full address
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a + 8'd3, a + 8'd2, a + 8'd1, a} ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [9:0] align_adr(input logic [9:0] adr, input tcb_siz_t siz);
    case (siz)
      TCB_BYTE: return adr;
      TCB_HALF: return {adr[9:1], 1'b0};
      default:  return {adr[9:2], 2'b00};
    endcase
  endfunction

  // low 2**siz bytes are significant
  function automatic logic [31:0] size_mask(input tcb_siz_t siz);
    case (siz)
      TCB_BYTE: return 32'h0000_00ff;
      TCB_HALF: return 32'h0000_ffff;
      default:  return 32'hffff_ffff;
    endcase
  endfunction

  // right-aligned read data from the model
  function automatic logic [31:0] model_read(input logic [9:0] adr, input tcb_siz_t siz);
    logic [9:0] adr_al;
    logic [7:0] a;
    adr_al = align_adr(adr, siz);
    a = adr_al[7:0];
    return {mdl[a + 8'd3], mdl[a + 8'd2], mdl[a + 8'd1], mdl[a]} & size_mask(siz);
  endfunction

  // out of range writes are dropped
  function automatic void model_write(input logic [9:0] adr, input tcb_siz_t siz,
                                      input logic [31:0] wdt);
    logic [9:0] adr_al;
    logic [7:0] a;
    adr_al = align_adr(adr, siz);
    a = adr_al[7:0];
    if (adr < 10'd256) begin
      for (int i = 0; i < (1 << int'(siz)); i++) begin
        mdl[a + 8'(i)] = wdt[8*i +: 8];
      end
    end
  endfunction

  task automatic check_val(input string test, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  // one request, then wait for its response
  task automatic do_req(input logic wen, input logic [9:0] adr, input tcb_siz_t siz,
                        input logic [31:0] wdt, output tcb_rsp_t r);
    int unsigned cnt;
    @(negedge clk);
    req_vld = 1'b1;
    req.wen = wen;
    req.adr = adr;
    req.siz = siz;
    req.wdt = wdt;
    @(negedge clk);
    req_vld = 1'b0;
    cnt = 0;
    while (!rsp_vld && cnt < 20) begin
      @(negedge clk);
      cnt++;
    end
    if (rsp_vld) begin
      r = rsp;
    end else begin
      err_cnt++;
      r = '0;
      $display("no response from the DUT within 20 cycles");
    end
  endtask

  // request plus model update and response check
  task automatic access(input string test, input logic wen, input logic [9:0] adr,
                        input tcb_siz_t siz, input logic [31:0] wdt);
    tcb_rsp_t    r;
    logic [31:0] exp;
    exp = model_read(adr, siz);
    do_req(wen, adr, siz, wdt, r);
    if (adr >= 10'd256) begin
      check_val(test, 32'(TCB_ERR), 32'(r.sts));
      check_val(test, 32'h0, r.rdt);
    end else begin
      check_val(test, 32'(TCB_OK), 32'(r.sts));
      if (wen) model_write(adr, siz, wdt);
      else check_val(test, exp, r.rdt & size_mask(siz));
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_word();
    @(negedge clk);
    check_val("reset", 32'h0, 32'(rsp_vld));
    // defined contents everywhere
    for (int w = 0; w < 64; w++) begin
      access("fill", 1'b1, 10'(4 * w), TCB_WORD, fill_word(8'(4 * w)));
    end
    access("word", 1'b1, 10'h010, TCB_WORD, next_rand());
    access("word", 1'b0, 10'h010, TCB_WORD, 32'h0);
  endtask

  task automatic test_byte_write();
    for (int i = 0; i < 4; i++) begin
      access("byte_write", 1'b1, 10'(10'h020 + i), TCB_BYTE, next_rand());
    end
    access("byte_write", 1'b0, 10'h020, TCB_WORD, 32'h0);
    // neighbours untouched
    access("byte_write", 1'b0, 10'h01c, TCB_WORD, 32'h0);
    access("byte_write", 1'b0, 10'h024, TCB_WORD, 32'h0);
  endtask

  task automatic test_byte_half_read();
    access("sub_read", 1'b1, 10'h030, TCB_WORD, next_rand());
    for (int i = 0; i < 4; i++) begin
      access("sub_read", 1'b0, 10'(10'h030 + i), TCB_BYTE, 32'h0);
    end
    access("sub_read", 1'b0, 10'h030, TCB_HALF, 32'h0);
    access("sub_read", 1'b0, 10'h032, TCB_HALF, 32'h0);
  endtask

  task automatic test_half_write();
    access("half_write", 1'b1, 10'h042, TCB_HALF, next_rand());
    access("half_write", 1'b0, 10'h040, TCB_WORD, 32'h0);
    access("half_write", 1'b1, 10'h040, TCB_HALF, next_rand());
    access("half_write", 1'b0, 10'h040, TCB_WORD, 32'h0);
  endtask

  // one request per cycle, previous response checked on the way
  task automatic test_back_to_back();
    logic [31:0] rnd;
    logic [31:0] p_exp;
    logic [31:0] p_msk;
    logic        p_wen;
    logic [9:0]  adr;
    tcb_siz_t    siz;
    p_exp = '0;
    p_msk = '0;
    p_wen = 1'b1;
    for (int i = 0; i <= 32; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_val("back_to_back", 32'h1, 32'(rsp_vld));
        check_val("back_to_back", 32'(TCB_OK), 32'(rsp.sts));
        if (!p_wen) check_val("back_to_back", p_exp, rsp.rdt & p_msk);
      end
      if (i < 32) begin
        rnd = next_rand();
        siz = tcb_siz_t'(rnd[2:1] % 2'd3);
        adr = align_adr({4'b0010, rnd[8:3]}, siz);
        p_wen = rnd[0];
        p_exp = model_read(adr, siz);
        p_msk = size_mask(siz);
        req_vld = 1'b1;
        req.wen = p_wen;
        req.adr = adr;
        req.siz = siz;
        req.wdt = next_rand();
        if (p_wen) model_write(adr, siz, req.wdt);
      end else begin
        req_vld = 1'b0;
      end
    end
  endtask

  task automatic test_out_of_range();
    access("out_of_range", 1'b1, 10'h100, TCB_WORD, next_rand());
    access("out_of_range", 1'b0, 10'h104, TCB_WORD, 32'h0);
    access("out_of_range", 1'b0, 10'h3ff, TCB_BYTE, 32'h0);
    // 0x100 shares its low index bits with word 0
    access("out_of_range", 1'b0, 10'h000, TCB_WORD, 32'h0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    rst_n     = 1'b0;
    req_vld   = 1'b0;
    req       = '0;
    err_cnt   = 0;
    chk_cnt   = 0;
    rnd_state = 32'h83b1;
    // reset seen by 8 rising edges
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_word();
    test_byte_write();
    test_byte_half_read();
    test_half_write();
    test_back_to_back();
    test_out_of_range();
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule: tcb_tb
